/* vlog.f */
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_mem.sv
hdl/rv_hazard.sv
hdl/rv_pipeline.sv
dv/rv_pipeline_assert.sv
dv/tb_rv_pipeline.sv

/* Bender.yml */
package:
  name: rv_pipeline

sources:
  - hdl/rv_pkg.sv
  - hdl/rv_fetch.sv
  - hdl/rv_regfile.sv
  - hdl/rv_decode.sv
  - hdl/rv_execute.sv
  - hdl/rv_mem.sv
  - hdl/rv_hazard.sv
  - hdl/rv_pipeline.sv
  - target: test
    files:
      - dv/rv_pipeline_assert.sv
      - dv/tb_rv_pipeline.sv

/* dv/tb_rv_pipeline.sv */
`timescale 1ns/1ns

module tb_rv_pipeline import rv_pkg::*; ();

    localparam logic [31:0] RESET_PC       = 32'h0000_0100;
    localparam logic [31:0] SEED           = 32'd82591;
    localparam int          MEM_WORDS      = 256;
    localparam int          TIMEOUT_CYCLES = 2000;
    // sentinel store goes to the last data word
    localparam logic [11:0] SENTINEL_OFS   = 12'h3FC;
    localparam int          STALL_OFF      = 0;
    localparam int          STALL_RANDOM   = 1;
    localparam int          STALL_HOLD     = 2;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        icache_stall = 1'b0;
    logic        icache_ren;
    logic [29:0] icache_addr;
    logic [31:0] icache_rdata;
    logic        dcache_stall = 1'b0;
    logic        dcache_ren;
    logic        dcache_wen;
    logic [29:0] dcache_addr;
    logic [31:0] dcache_rdata;
    logic [31:0] dcache_wdata;

    logic [31:0] imem [0:MEM_WORDS-1];
    logic [31:0] dmem [0:MEM_WORDS-1];
    int          pc_word;
    int          sentinel_count = 0;
    int          stall_mode = STALL_OFF;
    int          hold_cnt = 0;
    logic [31:0] rng_q = SEED;

    rv_pipeline #(
        .RESET_PC(RESET_PC)
    ) UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .ICACHE_stall_i(icache_stall),
        .ICACHE_ren_o  (icache_ren),
        .ICACHE_addr_o (icache_addr),
        .ICACHE_rdata_i(icache_rdata),
        .DCACHE_stall_i(dcache_stall),
        .DCACHE_ren_o  (dcache_ren),
        .DCACHE_wen_o  (dcache_wen),
        .DCACHE_addr_o (dcache_addr),
        .DCACHE_rdata_i(dcache_rdata),
        .DCACHE_wdata_o(dcache_wdata)
    );

    always #4 clk = ~clk;

    // single-cycle memories answering both cache ports
    assign icache_rdata = imem[icache_addr[7:0]];
    assign dcache_rdata = dmem[dcache_addr[7:0]];

    always @(posedge clk) begin
        if (rst_n && dcache_wen && !dcache_stall) begin
            dmem[dcache_addr[7:0]] <= dcache_wdata;
            if (dcache_addr == {20'd0, SENTINEL_OFS[11:2]}) begin
                sentinel_count <= sentinel_count + 1;
            end
        end
    end

    // stall patterns, changed on the falling edge
    always @(negedge clk) begin
        rng_q = lcg_next(rng_q);
        if (!rst_n || stall_mode == STALL_OFF) begin
            icache_stall = 1'b0;
            dcache_stall = 1'b0;
            hold_cnt     = 0;
        end else if (stall_mode == STALL_RANDOM) begin
            icache_stall = (rng_q[17:16] == 2'b00);
            dcache_stall = (rng_q[27:26] == 2'b00) || (rng_q[29:28] == 2'b00);
        end else begin
            // every data access waits four cycles
            icache_stall = 1'b0;
            if (hold_cnt != 0) begin
                hold_cnt     = hold_cnt - 1;
                dcache_stall = (hold_cnt != 0);
            end else if (dcache_ren || dcache_wen) begin
                dcache_stall = 1'b1;
                hold_cnt     = 4;
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] fill_word(input int i);
        return 32'h5A00_0000 ^ (i * 32'h0001_0101);
    endfunction

    function automatic logic [31:0] enc_alu(input alu_op_e op, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
        logic [9:0] f;
        case (op)
            ALU_SUB: f = {7'h20, 3'b000};
            ALU_AND: f = {7'h00, 3'b111};
            ALU_OR:  f = {7'h00, 3'b110};
            ALU_XOR: f = {7'h00, 3'b100};
            ALU_SLT: f = {7'h00, 3'b010};
            ALU_MUL: f = {7'h01, 3'b000};
            default: f = {7'h00, 3'b000};
        endcase
        return {f[9:3], rs2, rs1, f[2:0], rd, OP};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, LOAD};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] enc_branch(input logic is_bne, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 2'b00, is_bne, off[4:1], off[11], BRANCH};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic emit(input logic [31:0] inst);
        imem[pc_word] = inst;
        pc_word       = pc_word + 1;
    endtask

    // sentinel store, then spin in place
    task automatic finish_program();
        emit(enc_sw(5'd0, 5'd0, SENTINEL_OFS));
        emit(enc_jal(5'd0, 21'd0));
    endtask

    task automatic start_test(input int mode);
        @(negedge clk);
        rst_n      <= 1'b0;
        stall_mode <= mode;
        for (int i = 0; i < MEM_WORDS; i++) begin
            // opcode zero is illegal and decodes to a bubble
            imem[i] = {i[24:0], 7'h00};
            dmem[i] = fill_word(i);
        end
        pc_word = RESET_PC / 4;
    endtask

    task automatic release_reset();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic wait_sentinel(input string name);
        int start_cnt;
        int cycles;
        start_cnt = sentinel_count;
        cycles    = 0;
        while (sentinel_count == start_cnt && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (sentinel_count == start_cnt) begin
            abort_run($sformatf("%s timed out, no sentinel store after %0d cycles",
                                name, cycles));
        end
    endtask

    task automatic test_reset_state();
        start_test(STALL_OFF);
        emit(enc_jal(5'd0, 21'd0));
        release_reset();
        check("reset icache_addr", RESET_PC / 4, {2'b00, icache_addr});
        check("reset icache_ren", 32'd1, {31'd0, icache_ren});
        check("reset dcache_ren", 32'd0, {31'd0, dcache_ren});
        check("reset dcache_wen", 32'd0, {31'd0, dcache_wen});
    endtask

    // each op uses the result just before it
    task automatic test_alu_chain(input int mode, input string name);
        logic [31:0] e [1:13];
        start_test(mode);
        emit(enc_addi(5'd1, 5'd0, 12'd1234));
        emit(enc_addi(5'd2, 5'd1, -12'sd3));
        emit(enc_alu(ALU_ADD, 5'd3, 5'd1, 5'd2));
        emit(enc_alu(ALU_SUB, 5'd4, 5'd3, 5'd1));
        emit(enc_alu(ALU_MUL, 5'd5, 5'd4, 5'd3));
        emit(enc_alu(ALU_XOR, 5'd6, 5'd5, 5'd1));
        emit(enc_alu(ALU_OR, 5'd7, 5'd6, 5'd2));
        emit(enc_alu(ALU_AND, 5'd8, 5'd7, 5'd5));
        emit(enc_alu(ALU_SLT, 5'd9, 5'd4, 5'd8));
        emit(enc_addi(5'd10, 5'd0, -12'sd5));
        emit(enc_alu(ALU_SLT, 5'd11, 5'd10, 5'd9));
        emit(enc_alu(ALU_MUL, 5'd12, 5'd10, 5'd5));
        // x0 write has to be dropped
        emit(enc_addi(5'd0, 5'd1, 12'd9));
        emit(enc_alu(ALU_ADD, 5'd13, 5'd0, 5'd12));
        for (int r = 1; r <= 13; r++) begin
            emit(enc_sw(r, 5'd0, 4 * (r - 1)));
        end
        emit(enc_sw(5'd0, 5'd0, 12'd56));
        finish_program();
        release_reset();
        wait_sentinel(name);
        e[1]  = 32'd1234;
        e[2]  = e[1] - 32'd3;
        e[3]  = e[1] + e[2];
        e[4]  = e[3] - e[1];
        e[5]  = e[4] * e[3];
        e[6]  = e[5] ^ e[1];
        e[7]  = e[6] | e[2];
        e[8]  = e[7] & e[5];
        e[9]  = ($signed(e[4]) < $signed(e[8])) ? 32'd1 : 32'd0;
        e[10] = 32'hFFFF_FFFB;
        e[11] = ($signed(e[10]) < $signed(e[9])) ? 32'd1 : 32'd0;
        e[12] = e[10] * e[5];
        e[13] = e[12];
        for (int r = 1; r <= 13; r++) begin
            check($sformatf("%s x%0d", name, r), e[r], dmem[r - 1]);
        end
        check($sformatf("%s x0", name), 32'd0, dmem[14]);
    endtask

    task automatic test_load_use();
        logic [31:0] d0;
        logic [31:0] d1;
        d0 = lcg_next(SEED);
        d1 = lcg_next(d0);
        start_test(STALL_OFF);
        dmem[16] = d0;
        dmem[17] = d1;
        emit(enc_lw(5'd2, 5'd0, 12'd64));
        emit(enc_alu(ALU_ADD, 5'd3, 5'd2, 5'd2));
        emit(enc_lw(5'd4, 5'd0, 12'd68));
        emit(enc_addi(5'd5, 5'd4, 12'd1));
        emit(enc_alu(ALU_ADD, 5'd6, 5'd3, 5'd5));
        // loaded word used at once as store data
        emit(enc_lw(5'd7, 5'd0, 12'd64));
        emit(enc_sw(5'd7, 5'd0, 12'd12));
        emit(enc_sw(5'd3, 5'd0, 12'd0));
        emit(enc_sw(5'd5, 5'd0, 12'd4));
        emit(enc_sw(5'd6, 5'd0, 12'd8));
        finish_program();
        release_reset();
        wait_sentinel("load_use");
        check("load_use double", d0 + d0, dmem[0]);
        check("load_use addi", d1 + 32'd1, dmem[1]);
        check("load_use sum", d0 + d0 + d1 + 32'd1, dmem[2]);
        check("load_use store", d0, dmem[3]);
    endtask

    task automatic test_branches();
        logic [31:0] link;
        start_test(STALL_OFF);
        emit(enc_addi(5'd1, 5'd0, 12'd5));
        emit(enc_addi(5'd2, 5'd0, 12'd5));
        emit(enc_addi(5'd3, 5'd0, 12'd6));
        // taken beq, two marker stores behind it
        emit(enc_branch(1'b0, 5'd1, 5'd2, 13'd12));
        emit(enc_sw(5'd1, 5'd0, 12'd160));
        emit(enc_sw(5'd1, 5'd0, 12'd164));
        emit(enc_branch(1'b1, 5'd1, 5'd2, 13'd12));
        emit(enc_addi(5'd4, 5'd0, 12'd11));
        emit(enc_branch(1'b0, 5'd1, 5'd3, 13'd8));
        emit(enc_addi(5'd5, 5'd0, 12'd22));
        emit(enc_branch(1'b1, 5'd1, 5'd3, 13'd12));
        emit(enc_sw(5'd1, 5'd0, 12'd168));
        emit(enc_sw(5'd1, 5'd0, 12'd172));
        link = pc_word * 4 + 4;
        emit(enc_jal(5'd6, 21'd12));
        emit(enc_sw(5'd1, 5'd0, 12'd176));
        emit(enc_sw(5'd1, 5'd0, 12'd180));
        emit(enc_sw(5'd4, 5'd0, 12'd0));
        emit(enc_sw(5'd5, 5'd0, 12'd4));
        emit(enc_sw(5'd6, 5'd0, 12'd8));
        finish_program();
        release_reset();
        wait_sentinel("branches");
        check("branches bne not taken", 32'd11, dmem[0]);
        check("branches beq not taken", 32'd22, dmem[1]);
        check("branches jal link", link, dmem[2]);
        for (int w = 40; w < 46; w++) begin
            check($sformatf("branches marker word %0d", w), fill_word(w), dmem[w]);
        end
    endtask

    task automatic test_store_load();
        logic [31:0] v;
        start_test(STALL_HOLD);
        emit(enc_addi(5'd1, 5'd0, 12'd1365));
        emit(enc_alu(ALU_MUL, 5'd2, 5'd1, 5'd1));
        emit(enc_alu(ALU_MUL, 5'd2, 5'd2, 5'd1));
        emit(enc_sw(5'd2, 5'd0, 12'd128));
        emit(enc_lw(5'd3, 5'd0, 12'd128));
        emit(enc_addi(5'd4, 5'd3, 12'd1));
        emit(enc_sw(5'd4, 5'd0, 12'd132));
        emit(enc_sw(5'd3, 5'd0, 12'd136));
        finish_program();
        release_reset();
        wait_sentinel("store_load");
        v = 32'd1365 * 32'd1365 * 32'd1365;
        check("store_load stored", v, dmem[32]);
        check("store_load plus one", v + 32'd1, dmem[33]);
        check("store_load loaded", v, dmem[34]);
    endtask

    initial begin
        test_reset_state();
        test_alu_chain(STALL_OFF, "alu_chain");
        test_load_use();
        test_branches();
        test_alu_chain(STALL_RANDOM, "alu_chain_stalls");
        test_store_load();
        $display("TEST OK");
        $finish;
    end

endmodule

/* dv/rv_pipeline_assert.sv */
`timescale 1ns/1ns

module rv_pipeline_assert (
    input logic        clk,
    input logic        rst_n,
    input logic        icache_stall_i,
    input logic [29:0] icache_addr_i,
    input logic        dcache_stall_i,
    input logic        dcache_ren_i,
    input logic        dcache_wen_i,
    input logic [29:0] dcache_addr_i,
    input logic [31:0] dcache_wdata_i,
    input logic        redirect_i,
    input logic [31:0] redirect_pc_i
);

    logic [29:0] target_q;

    // last redirect target, fetch may take it a few cycles late
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            target_q <= '0;
        end else if (redirect_i) begin
            target_q <= redirect_pc_i[31:2];
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !(dcache_ren_i && dcache_wen_i))
        else $error("data read and write strobes high together");

    assert property (@(posedge clk) disable iff (!rst_n)
        icache_stall_i |=> $stable(icache_addr_i))
        else $error("instruction address moved during a stall");

    assert property (@(posedge clk) disable iff (!rst_n)
        dcache_stall_i && (dcache_ren_i || dcache_wen_i) |=>
            $stable(dcache_ren_i) && $stable(dcache_wen_i) &&
            $stable(dcache_addr_i) && $stable(dcache_wdata_i))
        else $error("data request changed during a stall");

    assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(icache_addr_i) |->
            (icache_addr_i == $past(icache_addr_i) + 30'd1) || (icache_addr_i == target_q))
        else $error("instruction address neither stepped nor followed a redirect");

endmodule

bind rv_pipeline rv_pipeline_assert u_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .icache_stall_i(ICACHE_stall_i),
    .icache_addr_i (ICACHE_addr_o),
    .dcache_stall_i(DCACHE_stall_i),
    .dcache_ren_i  (DCACHE_ren_o),
    .dcache_wen_i  (DCACHE_wen_o),
    .dcache_addr_i (DCACHE_addr_o),
    .dcache_wdata_i(DCACHE_wdata_o),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc)
);

/* hdl/rv_pipeline.sv */
`timescale 1ns/1ns

module rv_pipeline import rv_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ICACHE_stall_i,
    output logic        ICACHE_ren_o,
    output logic [29:0] ICACHE_addr_o,
    input  logic [31:0] ICACHE_rdata_i,
    input  logic        DCACHE_stall_i,
    output logic        DCACHE_ren_o,
    output logic        DCACHE_wen_o,
    output logic [29:0] DCACHE_addr_o,
    input  logic [31:0] DCACHE_rdata_i,
    output logic [31:0] DCACHE_wdata_o
);

    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    mem_wb_t     mem_wb;
    logic [4:0]  id_rs1;
    logic [4:0]  id_rs2;
    logic [31:0] id_rs1_data;
    logic [31:0] id_rs2_data;
    fwd_sel_e    fwd_a;
    fwd_sel_e    fwd_b;
    logic        freeze_all;
    logic        hold_front;
    logic        bubble_ex;
    logic        flush_front;
    logic        redirect;
    logic [31:0] redirect_pc;

    rv_fetch #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .hold_i        (hold_front),
        .flush_i       (flush_front),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .ICACHE_stall_i(ICACHE_stall_i),
        .ICACHE_rdata_i(ICACHE_rdata_i),
        .ICACHE_ren_o  (ICACHE_ren_o),
        .ICACHE_addr_o (ICACHE_addr_o),
        .if_id_o       (if_id)
    );

    rv_regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_i     (id_rs1),
        .rs2_i     (id_rs2),
        .rs1_data_o(id_rs1_data),
        .rs2_data_o(id_rs2_data),
        .wb_i      (mem_wb)
    );

    // ID/EX only holds on a freeze, load-use puts a bubble in
    rv_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .hold_i    (freeze_all),
        .bubble_i  (bubble_ex),
        .flush_i   (flush_front),
        .if_id_i   (if_id),
        .rs1_o     (id_rs1),
        .rs2_o     (id_rs2),
        .rs1_data_i(id_rs1_data),
        .rs2_data_i(id_rs2_data),
        .id_ex_o   (id_ex)
    );

    rv_execute u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .freeze_i     (freeze_all),
        .id_ex_i      (id_ex),
        .fwd_a_i      (fwd_a),
        .fwd_b_i      (fwd_b),
        .mem_fwd_i    (ex_mem.result),
        .wb_fwd_i     (mem_wb.result),
        .redirect_o   (redirect),
        .redirect_pc_o(redirect_pc),
        .ex_mem_o     (ex_mem)
    );

    rv_mem u_mem (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_mem_i      (ex_mem),
        .DCACHE_stall_i(DCACHE_stall_i),
        .DCACHE_rdata_i(DCACHE_rdata_i),
        .DCACHE_ren_o  (DCACHE_ren_o),
        .DCACHE_wen_o  (DCACHE_wen_o),
        .DCACHE_addr_o (DCACHE_addr_o),
        .DCACHE_wdata_o(DCACHE_wdata_o),
        .mem_wb_o      (mem_wb)
    );

    rv_hazard u_hazard (
        .id_rs1_i      (id_rs1),
        .id_rs2_i      (id_rs2),
        .id_ex_i       (id_ex),
        .ex_mem_i      (ex_mem),
        .mem_wb_i      (mem_wb),
        .DCACHE_stall_i(DCACHE_stall_i),
        .redirect_i    (redirect),
        .fwd_a_o       (fwd_a),
        .fwd_b_o       (fwd_b),
        .freeze_all_o  (freeze_all),
        .hold_front_o  (hold_front),
        .bubble_ex_o   (bubble_ex),
        .flush_front_o (flush_front)
    );

endmodule

/* hdl/rv_hazard.sv */
`timescale 1ns/1ns

module rv_hazard import rv_pkg::*; (
    input  logic [4:0] id_rs1_i,
    input  logic [4:0] id_rs2_i,
    input  id_ex_t     id_ex_i,
    input  ex_mem_t    ex_mem_i,
    input  mem_wb_t    mem_wb_i,
    input  logic       DCACHE_stall_i,
    input  logic       redirect_i,
    output fwd_sel_e   fwd_a_o,
    output fwd_sel_e   fwd_b_o,
    output logic       freeze_all_o,
    output logic       hold_front_o,
    output logic       bubble_ex_o,
    output logic       flush_front_o
);

    logic freeze;
    logic load_use;

    // memory stage wins over writeback, x0 never forwards
    function automatic fwd_sel_e pick_fwd(input logic [4:0] rs);
        if (rs == 5'd0) begin
            return FWD_NONE;
        end
        // a load's memory-stage result is its address, never its data
        if (ex_mem_i.valid && ex_mem_i.reg_wen && !ex_mem_i.mem_ren && ex_mem_i.rd == rs) begin
            return FWD_MEM;
        end
        // reg_wen is qualified in mem, and survives a freeze while valid drops
        if (mem_wb_i.reg_wen && mem_wb_i.rd == rs) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign fwd_a_o = pick_fwd(id_ex_i.rs1);
    assign fwd_b_o = pick_fwd(id_ex_i.rs2);

    assign freeze = DCACHE_stall_i && ex_mem_i.valid && (ex_mem_i.mem_ren || ex_mem_i.mem_wen);

    // load in EX feeding the instruction in ID
    assign load_use = id_ex_i.valid && id_ex_i.mem_ren && (id_ex_i.rd != 5'd0) &&
                      ((id_ex_i.rd == id_rs1_i) || (id_ex_i.rd == id_rs2_i));

    assign freeze_all_o  = freeze;
    assign hold_front_o  = freeze || load_use;
    assign bubble_ex_o   = load_use && !freeze;
    // a frozen branch redirects once the freeze lifts
    assign flush_front_o = redirect_i && !freeze;

endmodule

/* hdl/rv_mem.sv */
`timescale 1ns/1ns

module rv_mem import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  ex_mem_t     ex_mem_i,
    input  logic        DCACHE_stall_i,
    input  logic [31:0] DCACHE_rdata_i,
    output logic        DCACHE_ren_o,
    output logic        DCACHE_wen_o,
    output logic [29:0] DCACHE_addr_o,
    output logic [31:0] DCACHE_wdata_o,
    output mem_wb_t     mem_wb_o
);

    logic        stalled;
    logic [31:0] wb_value;
    mem_wb_t     mem_wb_q;

    assign DCACHE_ren_o   = ex_mem_i.valid && ex_mem_i.mem_ren;
    assign DCACHE_wen_o   = ex_mem_i.valid && ex_mem_i.mem_wen;
    assign DCACHE_addr_o  = ex_mem_i.result[31:2];
    assign DCACHE_wdata_o = ex_mem_i.store_data;

    // a stall only counts against an access in flight
    assign stalled  = DCACHE_stall_i && (DCACHE_ren_o || DCACHE_wen_o);
    assign wb_value = ex_mem_i.mem_ren ? DCACHE_rdata_i : ex_mem_i.result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb_q <= '0;
        end else if (stalled) begin
            // rd, result and reg_wen stay put so the entry can still forward
            mem_wb_q.valid <= 1'b0;
        end else begin
            mem_wb_q.valid   <= ex_mem_i.valid;
            mem_wb_q.reg_wen <= ex_mem_i.valid && ex_mem_i.reg_wen;
            mem_wb_q.rd      <= ex_mem_i.rd;
            mem_wb_q.result  <= wb_value;
        end
    end

    assign mem_wb_o = mem_wb_q;

endmodule

/* hdl/rv_execute.sv */
`timescale 1ns/1ns

module rv_execute import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        freeze_i,
    input  id_ex_t      id_ex_i,
    input  fwd_sel_e    fwd_a_i,
    input  fwd_sel_e    fwd_b_i,
    input  logic [31:0] mem_fwd_i,
    input  logic [31:0] wb_fwd_i,
    output logic        redirect_o,
    output logic [31:0] redirect_pc_o,
    output ex_mem_t     ex_mem_o
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_b;
    logic [31:0] alu_res;
    logic        taken;
    ex_mem_t     ex_mem_q;

    function automatic logic [31:0] fwd_mux(input fwd_sel_e sel, input logic [31:0] reg_val);
        case (sel)
            FWD_MEM: return mem_fwd_i;
            FWD_WB:  return wb_fwd_i;
            default: return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a_i, id_ex_i.rs1_data);
    assign op_b  = fwd_mux(fwd_b_i, id_ex_i.rs2_data);
    assign alu_b = id_ex_i.alu_src_imm ? id_ex_i.imm : op_b;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_SUB: alu_res = op_a - alu_b;
            ALU_AND: alu_res = op_a & alu_b;
            ALU_OR:  alu_res = op_a | alu_b;
            ALU_XOR: alu_res = op_a ^ alu_b;
            ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(alu_b)};
            // low word of the product
            ALU_MUL: alu_res = op_a * alu_b;
            default: alu_res = op_a + alu_b;
        endcase
    end

    // predicted not-taken, so any taken branch or jal redirects
    assign taken = id_ex_i.valid &&
                   (id_ex_i.jal || (id_ex_i.branch && ((op_a == op_b) != id_ex_i.bne)));
    assign redirect_o    = taken;
    assign redirect_pc_o = id_ex_i.pc + id_ex_i.imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem_q <= '0;
        end else if (!freeze_i) begin
            ex_mem_q.valid      <= id_ex_i.valid;
            ex_mem_q.result     <= id_ex_i.jal ? id_ex_i.pc + 32'd4 : alu_res;
            ex_mem_q.store_data <= op_b;
            ex_mem_q.rd         <= id_ex_i.rd;
            ex_mem_q.mem_ren    <= id_ex_i.mem_ren;
            ex_mem_q.mem_wen    <= id_ex_i.mem_wen;
            ex_mem_q.reg_wen    <= id_ex_i.reg_wen;
        end
    end

    assign ex_mem_o = ex_mem_q;

endmodule

/* hdl/rv_decode.sv */
`timescale 1ns/1ns

module rv_decode import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hold_i,
    input  logic        bubble_i,
    input  logic        flush_i,
    input  if_id_t      if_id_i,
    output logic [4:0]  rs1_o,
    output logic [4:0]  rs2_o,
    input  logic [31:0] rs1_data_i,
    input  logic [31:0] rs2_data_i,
    output id_ex_t      id_ex_o
);

    logic [31:0] inst;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        legal;
    id_ex_t      dec;
    id_ex_t      id_ex_q;

    assign inst   = if_id_i.inst;
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1_o  = inst[19:15];
    assign rs2_o  = inst[24:20];

    // immediates, sign taken from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec          = '0;
        legal        = 1'b0;
        dec.pc       = if_id_i.pc;
        dec.rs1      = rs1_o;
        dec.rs2      = rs2_o;
        dec.rd       = inst[11:7];
        dec.rs1_data = rs1_data_i;
        dec.rs2_data = rs2_data_i;
        case (opcode_e'(inst[6:0]))
            OP: begin
                legal       = 1'b1;
                dec.reg_wen = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec.alu_op = ALU_ADD;
                    {7'h20, 3'b000}: dec.alu_op = ALU_SUB;
                    {7'h00, 3'b111}: dec.alu_op = ALU_AND;
                    {7'h00, 3'b110}: dec.alu_op = ALU_OR;
                    {7'h00, 3'b100}: dec.alu_op = ALU_XOR;
                    {7'h00, 3'b010}: dec.alu_op = ALU_SLT;
                    {7'h01, 3'b000}: dec.alu_op = ALU_MUL;
                    default:         legal      = 1'b0;
                endcase
            end
            OP_IMM: begin
                // only addi
                legal           = (funct3 == 3'b000);
                dec.reg_wen     = 1'b1;
                dec.alu_src_imm = 1'b1;
                dec.imm         = imm_i;
            end
            LOAD: begin
                legal           = (funct3 == 3'b010);
                dec.mem_ren     = 1'b1;
                dec.reg_wen     = 1'b1;
                dec.alu_src_imm = 1'b1;
                dec.imm         = imm_i;
            end
            STORE: begin
                legal           = (funct3 == 3'b010);
                dec.mem_wen     = 1'b1;
                dec.alu_src_imm = 1'b1;
                dec.imm         = imm_s;
            end
            BRANCH: begin
                // beq is 000, bne is 001
                legal      = (funct3[2:1] == 2'b00);
                dec.branch = 1'b1;
                dec.bne    = funct3[0];
                dec.imm    = imm_b;
            end
            JAL: begin
                legal       = 1'b1;
                dec.jal     = 1'b1;
                dec.reg_wen = 1'b1;
                dec.imm     = imm_j;
            end
            default: legal = 1'b0;
        endcase
        dec.valid = if_id_i.valid && legal;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex_q <= '0;
        end else if (!hold_i) begin
            id_ex_q <= dec;
            // load-use bubble or squash behind a taken branch
            if (bubble_i || flush_i) begin
                id_ex_q.valid <= 1'b0;
            end
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ns

module rv_regfile import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o,
    input  mem_wb_t     wb_i
);

    logic [31:0] regs [1:31];
    logic        wen;

    assign wen = wb_i.valid && wb_i.reg_wen && (wb_i.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wen) begin
            regs[wb_i.rd] <= wb_i.result;
        end
    end

    // x0 reads zero, same-cycle write is passed straight through
    assign rs1_data_o = (rs1_i == 5'd0) ? 32'd0 :
                        (wen && wb_i.rd == rs1_i) ? wb_i.result : regs[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? 32'd0 :
                        (wen && wb_i.rd == rs2_i) ? wb_i.result : regs[rs2_i];

endmodule

/* hdl/rv_fetch.sv */
`timescale 1ns/1ns

module rv_fetch import rv_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hold_i,
    input  logic        flush_i,
    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,
    input  logic        ICACHE_stall_i,
    input  logic [31:0] ICACHE_rdata_i,
    output logic        ICACHE_ren_o,
    output logic [29:0] ICACHE_addr_o,
    output if_id_t      if_id_o
);

    logic [31:0] pc_q;
    logic        pend_q;
    logic [31:0] pend_pc_q;
    if_id_t      if_id_q;

    // the core always wants the next instruction
    assign ICACHE_ren_o  = 1'b1;
    assign ICACHE_addr_o = pc_q[31:2];
    assign if_id_o       = if_id_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q    <= RESET_PC;
            pend_q  <= 1'b0;
            if_id_q <= '0;
        end else if (!hold_i) begin
            if (ICACHE_stall_i) begin
                // request must stay put, so park the redirect for later
                if (redirect_i) begin
                    pend_q    <= 1'b1;
                    pend_pc_q <= redirect_pc_i;
                end
            end else if (redirect_i) begin
                pc_q   <= redirect_pc_i;
                pend_q <= 1'b0;
            end else if (pend_q) begin
                pc_q   <= pend_pc_q;
                pend_q <= 1'b0;
            end else begin
                pc_q <= pc_q + 32'd4;
            end
            // word fetched under a parked redirect is from the wrong path
            if_id_q.valid <= !ICACHE_stall_i && !flush_i && !pend_q;
            if_id_q.pc    <= pc_q;
            if_id_q.inst  <= ICACHE_rdata_i;
        end
    end

endmodule

/* hdl/rv_pkg.sv */
package rv_pkg;

    // base opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_MUL
    } alu_op_e;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        alu_op_e     alu_op;
        logic        alu_src_imm;
        logic        branch;
        logic        bne;
        logic        jal;
        logic        mem_ren;
        logic        mem_wen;
        logic        reg_wen;
    } id_ex_t;

    // result is the alu value, or pc+4 for jal
    typedef struct packed {
        logic        valid;
        logic [31:0] result;
        logic [31:0] store_data;
        logic [4:0]  rd;
        logic        mem_ren;
        logic        mem_wen;
        logic        reg_wen;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] result;
        logic [4:0]  rd;
        logic        reg_wen;
    } mem_wb_t;

endpackage
